// ==== Bender.yml ====
package:
  name: mips_execute_stage

sources:
  - files:
      - mips_ex_pkg.sv
      - alu.sv
      - forwarding_unit.sv
      - instruction_execute.sv
      - execute_stage.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clock_gen.sv
      - tb_execute_stage.sv

// ==== alu.sv ====
`timescale 1ns/1ps

module alu (
    input  mips_ex_pkg::alu_op_e              i_op,
    input  logic [mips_ex_pkg::NB_DATA-1:0]   i_data_a,
    input  logic [mips_ex_pkg::NB_DATA-1:0]   i_data_b,
    input  logic [4:0]                        i_shamt,
    output logic [mips_ex_pkg::NB_DATA-1:0]   o_result
);

    logic [4:0] var_shamt;
    logic       less_than;

    // variable shifts take the amount from rs
    assign var_shamt = i_data_a[4:0];
    assign less_than = $signed(i_data_a) < $signed(i_data_b);

    always_comb begin
        case (i_op)
            mips_ex_pkg::OP_ADD: begin
                o_result = i_data_a + i_data_b;
            end
            mips_ex_pkg::OP_SUB: begin
                o_result = i_data_a - i_data_b;
            end
            mips_ex_pkg::OP_AND: begin
                o_result = i_data_a & i_data_b;
            end
            mips_ex_pkg::OP_OR: begin
                o_result = i_data_a | i_data_b;
            end
            mips_ex_pkg::OP_XOR: begin
                o_result = i_data_a ^ i_data_b;
            end
            mips_ex_pkg::OP_NOR: begin
                o_result = ~(i_data_a | i_data_b);
            end
            mips_ex_pkg::OP_SLT: begin
                o_result = {{(mips_ex_pkg::NB_DATA-1){1'b0}}, less_than};
            end
            mips_ex_pkg::OP_SLL: begin
                o_result = i_data_b << i_shamt;
            end
            mips_ex_pkg::OP_SRL: begin
                o_result = i_data_b >> i_shamt;
            end
            mips_ex_pkg::OP_SRA: begin
                o_result = $signed(i_data_b) >>> i_shamt;
            end
            mips_ex_pkg::OP_SLLV: begin
                o_result = i_data_b << var_shamt;
            end
            mips_ex_pkg::OP_SRLV: begin
                o_result = i_data_b >> var_shamt;
            end
            mips_ex_pkg::OP_SRAV: begin
                o_result = $signed(i_data_b) >>> var_shamt;
            end
            mips_ex_pkg::OP_LUI: begin
                // immediate into the upper half
                o_result = {i_data_b[15:0], 16'h0000};
            end
            default: begin
                o_result = '0;
            end
        endcase
    end

endmodule

// ==== execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
    input  logic                            clk,
    input  logic                            i_rst_n,
    input  logic                            i_stall,
    input  logic                            i_halt,

    input  logic [mips_ex_pkg::NB_REG-1:0]  i_rs,
    input  logic [mips_ex_pkg::NB_REG-1:0]  i_rt,
    input  logic [mips_ex_pkg::NB_REG-1:0]  i_rd,
    input  logic [mips_ex_pkg::NB_DATA-1:0] i_reg_da,
    input  logic [mips_ex_pkg::NB_DATA-1:0] i_reg_db,
    input  logic [mips_ex_pkg::NB_DATA-1:0] i_immediate,
    input  logic [5:0]                      i_opcode,
    input  logic [5:0]                      i_func,
    input  logic [4:0]                      i_shamt,

    input  logic                            i_jump,
    input  logic                            i_reg_dst,
    input  logic                            i_mem2reg,
    input  logic                            i_mem_read,
    input  logic                            i_mem_write,
    input  logic                            i_reg_write,
    input  logic                            i_imm_flag,
    input  logic                            i_sign_flag,
    input  logic [1:0]                      i_alu_class,
    input  logic [1:0]                      i_width,

    input  logic                            i_memwb_reg_write,
    input  logic [mips_ex_pkg::NB_REG-1:0]  i_memwb_write_reg,
    input  logic [mips_ex_pkg::NB_DATA-1:0] i_memwb_result,

    output logic                            o_mem2reg,
    output logic                            o_mem_read,
    output logic                            o_mem_write,
    output logic                            o_reg_write,
    output logic                            o_jump,
    output logic                            o_sign_flag,
    output logic [1:0]                      o_width,
    output logic [mips_ex_pkg::NB_REG-1:0]  o_write_reg,
    output logic [mips_ex_pkg::NB_DATA-1:0] o_data4mem,
    output logic [mips_ex_pkg::NB_DATA-1:0] o_result
);

    mips_ex_pkg::fwd_sel_e fw_a;
    mips_ex_pkg::fwd_sel_e fw_b;

    // the registered ex/mem outputs double as the feedback path
    forwarding_unit forwarding_unit_inst (
        .i_rs              (i_rs),
        .i_rt              (i_rt),
        .i_exmem_reg_write (o_reg_write),
        .i_exmem_write_reg (o_write_reg),
        .i_memwb_reg_write (i_memwb_reg_write),
        .i_memwb_write_reg (i_memwb_write_reg),
        .o_fw_a            (fw_a),
        .o_fw_b            (fw_b)
    );

    instruction_execute instruction_execute_inst (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_stall        (i_stall),
        .i_halt         (i_halt),
        .i_rt           (i_rt),
        .i_rd           (i_rd),
        .i_reg_da       (i_reg_da),
        .i_reg_db       (i_reg_db),
        .i_immediate    (i_immediate),
        .i_opcode       (i_opcode),
        .i_func         (i_func),
        .i_shamt        (i_shamt),
        .i_jump         (i_jump),
        .i_reg_dst      (i_reg_dst),
        .i_mem2reg      (i_mem2reg),
        .i_mem_read     (i_mem_read),
        .i_mem_write    (i_mem_write),
        .i_reg_write    (i_reg_write),
        .i_imm_flag     (i_imm_flag),
        .i_sign_flag    (i_sign_flag),
        .i_alu_class    (i_alu_class),
        .i_width        (i_width),
        .i_fw_a         (fw_a),
        .i_fw_b         (fw_b),
        .i_output_exmem (o_result),
        .i_output_memwb (i_memwb_result),
        .o_mem2reg      (o_mem2reg),
        .o_mem_read     (o_mem_read),
        .o_mem_write    (o_mem_write),
        .o_reg_write    (o_reg_write),
        .o_jump         (o_jump),
        .o_sign_flag    (o_sign_flag),
        .o_width        (o_width),
        .o_write_reg    (o_write_reg),
        .o_data4mem     (o_data4mem),
        .o_result       (o_result)
    );

endmodule

// ==== flist.f ====
+incdir+.
mips_ex_pkg.sv
alu.sv
forwarding_unit.sv
instruction_execute.sv
execute_stage.sv
tb_clock_gen.sv
tb_execute_stage.sv

// ==== forwarding_unit.sv ====
`timescale 1ns/1ps

module forwarding_unit (
    input  logic [mips_ex_pkg::NB_REG-1:0]  i_rs,
    input  logic [mips_ex_pkg::NB_REG-1:0]  i_rt,
    input  logic                            i_exmem_reg_write,
    input  logic [mips_ex_pkg::NB_REG-1:0]  i_exmem_write_reg,
    input  logic                            i_memwb_reg_write,
    input  logic [mips_ex_pkg::NB_REG-1:0]  i_memwb_write_reg,
    output mips_ex_pkg::fwd_sel_e           o_fw_a,
    output mips_ex_pkg::fwd_sel_e           o_fw_b
);

    // ex/mem first since it holds the younger result
    function automatic mips_ex_pkg::fwd_sel_e fwd_select(
        input logic [mips_ex_pkg::NB_REG-1:0] src,
        input logic                           ex_we,
        input logic [mips_ex_pkg::NB_REG-1:0] ex_reg,
        input logic                           wb_we,
        input logic [mips_ex_pkg::NB_REG-1:0] wb_reg
    );
        if (ex_we && (ex_reg != '0) && (ex_reg == src)) begin
            return mips_ex_pkg::FWD_EXMEM;
        end else if (wb_we && (wb_reg != '0) && (wb_reg == src)) begin
            return mips_ex_pkg::FWD_MEMWB;
        end else begin
            return mips_ex_pkg::FWD_REG;
        end
    endfunction

    assign o_fw_a = fwd_select(
        i_rs,
        i_exmem_reg_write,
        i_exmem_write_reg,
        i_memwb_reg_write,
        i_memwb_write_reg
    );

    assign o_fw_b = fwd_select(
        i_rt,
        i_exmem_reg_write,
        i_exmem_write_reg,
        i_memwb_reg_write,
        i_memwb_write_reg
    );

endmodule

// ==== instruction_execute.sv ====
`timescale 1ns/1ps

module instruction_execute (
    input  logic                            clk,
    input  logic                            i_rst_n,
    input  logic                            i_stall,
    input  logic                            i_halt,

    input  logic [mips_ex_pkg::NB_REG-1:0]  i_rt,
    input  logic [mips_ex_pkg::NB_REG-1:0]  i_rd,
    input  logic [mips_ex_pkg::NB_DATA-1:0] i_reg_da,
    input  logic [mips_ex_pkg::NB_DATA-1:0] i_reg_db,
    input  logic [mips_ex_pkg::NB_DATA-1:0] i_immediate,
    input  logic [5:0]                      i_opcode,
    input  logic [5:0]                      i_func,
    input  logic [4:0]                      i_shamt,

    input  logic                            i_jump,
    input  logic                            i_reg_dst,
    input  logic                            i_mem2reg,
    input  logic                            i_mem_read,
    input  logic                            i_mem_write,
    input  logic                            i_reg_write,
    input  logic                            i_imm_flag,
    input  logic                            i_sign_flag,
    input  logic [1:0]                      i_alu_class,
    input  logic [1:0]                      i_width,

    input  mips_ex_pkg::fwd_sel_e           i_fw_a,
    input  mips_ex_pkg::fwd_sel_e           i_fw_b,
    input  logic [mips_ex_pkg::NB_DATA-1:0] i_output_exmem,
    input  logic [mips_ex_pkg::NB_DATA-1:0] i_output_memwb,

    output logic                            o_mem2reg,
    output logic                            o_mem_read,
    output logic                            o_mem_write,
    output logic                            o_reg_write,
    output logic                            o_jump,
    output logic                            o_sign_flag,
    output logic [1:0]                      o_width,
    output logic [mips_ex_pkg::NB_REG-1:0]  o_write_reg,
    output logic [mips_ex_pkg::NB_DATA-1:0] o_data4mem,
    output logic [mips_ex_pkg::NB_DATA-1:0] o_result
);

    mips_ex_pkg::alu_op_e              alu_op;
    logic [mips_ex_pkg::NB_DATA-1:0]   fwd_data_a;
    logic [mips_ex_pkg::NB_DATA-1:0]   fwd_data_b;
    logic [mips_ex_pkg::NB_DATA-1:0]   alu_data_b;
    logic [mips_ex_pkg::NB_DATA-1:0]   alu_result;
    logic [mips_ex_pkg::NB_REG-1:0]    write_reg;

    function automatic logic [mips_ex_pkg::NB_DATA-1:0] fwd_mux(
        input mips_ex_pkg::fwd_sel_e           sel,
        input logic [mips_ex_pkg::NB_DATA-1:0] reg_val,
        input logic [mips_ex_pkg::NB_DATA-1:0] exmem_val,
        input logic [mips_ex_pkg::NB_DATA-1:0] memwb_val
    );
        case (sel)
            mips_ex_pkg::FWD_REG:   return reg_val;
            mips_ex_pkg::FWD_MEMWB: return memwb_val;
            mips_ex_pkg::FWD_EXMEM: return exmem_val;
            default:                return '0;
        endcase
    endfunction

    // alu control
    always_comb begin
        case (i_alu_class)
            mips_ex_pkg::CLS_LOAD_STORE: begin
                alu_op = mips_ex_pkg::OP_ADD;
            end
            mips_ex_pkg::CLS_BRANCH: begin
                // difference goes on for the zero test
                alu_op = mips_ex_pkg::OP_SUB;
            end
            mips_ex_pkg::CLS_R_TYPE: begin
                case (i_func)
                    mips_ex_pkg::FN_SLL:  alu_op = mips_ex_pkg::OP_SLL;
                    mips_ex_pkg::FN_SRL:  alu_op = mips_ex_pkg::OP_SRL;
                    mips_ex_pkg::FN_SRA:  alu_op = mips_ex_pkg::OP_SRA;
                    mips_ex_pkg::FN_SLLV: alu_op = mips_ex_pkg::OP_SLLV;
                    mips_ex_pkg::FN_SRLV: alu_op = mips_ex_pkg::OP_SRLV;
                    mips_ex_pkg::FN_SRAV: alu_op = mips_ex_pkg::OP_SRAV;
                    mips_ex_pkg::FN_ADDU: alu_op = mips_ex_pkg::OP_ADD;
                    mips_ex_pkg::FN_SUBU: alu_op = mips_ex_pkg::OP_SUB;
                    mips_ex_pkg::FN_AND:  alu_op = mips_ex_pkg::OP_AND;
                    mips_ex_pkg::FN_OR:   alu_op = mips_ex_pkg::OP_OR;
                    mips_ex_pkg::FN_XOR:  alu_op = mips_ex_pkg::OP_XOR;
                    mips_ex_pkg::FN_NOR:  alu_op = mips_ex_pkg::OP_NOR;
                    mips_ex_pkg::FN_SLT:  alu_op = mips_ex_pkg::OP_SLT;
                    default:              alu_op = mips_ex_pkg::OP_ADD;
                endcase
            end
            mips_ex_pkg::CLS_I_TYPE: begin
                case (i_opcode)
                    mips_ex_pkg::OPC_ADDI: alu_op = mips_ex_pkg::OP_ADD;
                    mips_ex_pkg::OPC_SLTI: alu_op = mips_ex_pkg::OP_SLT;
                    mips_ex_pkg::OPC_ANDI: alu_op = mips_ex_pkg::OP_AND;
                    mips_ex_pkg::OPC_ORI:  alu_op = mips_ex_pkg::OP_OR;
                    mips_ex_pkg::OPC_XORI: alu_op = mips_ex_pkg::OP_XOR;
                    mips_ex_pkg::OPC_LUI:  alu_op = mips_ex_pkg::OP_LUI;
                    default:               alu_op = mips_ex_pkg::OP_ADD;
                endcase
            end
            default: begin
                alu_op = mips_ex_pkg::OP_ADD;
            end
        endcase
    end

    // operand select
    assign fwd_data_a = fwd_mux(i_fw_a, i_reg_da, i_output_exmem, i_output_memwb);
    assign fwd_data_b = fwd_mux(i_fw_b, i_reg_db, i_output_exmem, i_output_memwb);

    // store data keeps the forwarded rt value
    assign alu_data_b = i_imm_flag ? i_immediate : fwd_data_b;

    assign write_reg = i_reg_dst ? i_rt : i_rd;

    alu alu_inst (
        .i_op     (alu_op),
        .i_data_a (fwd_data_a),
        .i_data_b (alu_data_b),
        .i_shamt  (i_shamt),
        .o_result (alu_result)
    );

    // ex/mem register
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_mem2reg   <= 1'b0;
            o_mem_read  <= 1'b0;
            o_mem_write <= 1'b0;
            o_reg_write <= 1'b0;
            o_jump      <= 1'b0;
            o_sign_flag <= 1'b0;
            o_width     <= 2'b11;
            o_write_reg <= '0;
            o_data4mem  <= '0;
            o_result    <= '0;
        end else if (!i_halt) begin
            // a stall turns the slot into a bubble
            o_mem_read  <= i_mem_read  & ~i_stall;
            o_mem_write <= i_mem_write & ~i_stall;
            o_reg_write <= i_reg_write & ~i_stall;
            o_jump      <= i_jump      & ~i_stall;
            o_mem2reg   <= i_mem2reg;
            o_sign_flag <= i_sign_flag;
            o_width     <= i_width;
            o_write_reg <= write_reg;
            o_data4mem  <= fwd_data_b;
            o_result    <= alu_result;
        end
    end

endmodule

// ==== mips_ex_pkg.sv ====
package mips_ex_pkg;

    // datapath widths
    localparam int NB_DATA = 32;
    localparam int NB_REG  = 5;

    // r-type function field
    localparam logic [5:0] FN_SLL  = 6'b000000;
    localparam logic [5:0] FN_SRL  = 6'b000010;
    localparam logic [5:0] FN_SRA  = 6'b000011;
    localparam logic [5:0] FN_SLLV = 6'b000100;
    localparam logic [5:0] FN_SRLV = 6'b000110;
    localparam logic [5:0] FN_SRAV = 6'b000111;
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_NOR  = 6'b100111;
    localparam logic [5:0] FN_SLT  = 6'b101010;

    // i-type opcodes
    localparam logic [5:0] OPC_ADDI = 6'b001000;
    localparam logic [5:0] OPC_SLTI = 6'b001010;
    localparam logic [5:0] OPC_ANDI = 6'b001100;
    localparam logic [5:0] OPC_ORI  = 6'b001101;
    localparam logic [5:0] OPC_XORI = 6'b001110;
    localparam logic [5:0] OPC_LUI  = 6'b001111;

    // instruction class from the control unit
    typedef enum logic [1:0] {
        CLS_LOAD_STORE = 2'b00,
        CLS_BRANCH     = 2'b01,
        CLS_R_TYPE     = 2'b10,
        CLS_I_TYPE     = 2'b11
    } alu_class_e;

    // operand source where 01 is unused and reads as zero
    typedef enum logic [1:0] {
        FWD_REG   = 2'b00,
        FWD_MEMWB = 2'b10,
        FWD_EXMEM = 2'b11
    } fwd_sel_e;

    // internal alu operations
    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_NOR  = 4'd5,
        OP_SLT  = 4'd6,
        OP_SLL  = 4'd7,
        OP_SRL  = 4'd8,
        OP_SRA  = 4'd9,
        OP_SLLV = 4'd10,
        OP_SRLV = 4'd11,
        OP_SRAV = 4'd12,
        OP_LUI  = 4'd13
    } alu_op_e;

endpackage

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule

// ==== tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// expected alu operation from class and function or opcode
function automatic mips_ex_pkg::alu_op_e ref_alu_op(
    input logic [1:0] cls,
    input logic [5:0] fn,
    input logic [5:0] opc
);
    mips_ex_pkg::alu_op_e op;
    op = mips_ex_pkg::OP_ADD;
    if (cls == mips_ex_pkg::CLS_BRANCH) begin
        op = mips_ex_pkg::OP_SUB;
    end else if (cls == mips_ex_pkg::CLS_R_TYPE) begin
        case (fn)
            mips_ex_pkg::FN_SLL:  op = mips_ex_pkg::OP_SLL;
            mips_ex_pkg::FN_SRL:  op = mips_ex_pkg::OP_SRL;
            mips_ex_pkg::FN_SRA:  op = mips_ex_pkg::OP_SRA;
            mips_ex_pkg::FN_SLLV: op = mips_ex_pkg::OP_SLLV;
            mips_ex_pkg::FN_SRLV: op = mips_ex_pkg::OP_SRLV;
            mips_ex_pkg::FN_SRAV: op = mips_ex_pkg::OP_SRAV;
            mips_ex_pkg::FN_SUBU: op = mips_ex_pkg::OP_SUB;
            mips_ex_pkg::FN_AND:  op = mips_ex_pkg::OP_AND;
            mips_ex_pkg::FN_OR:   op = mips_ex_pkg::OP_OR;
            mips_ex_pkg::FN_XOR:  op = mips_ex_pkg::OP_XOR;
            mips_ex_pkg::FN_NOR:  op = mips_ex_pkg::OP_NOR;
            mips_ex_pkg::FN_SLT:  op = mips_ex_pkg::OP_SLT;
            default:              op = mips_ex_pkg::OP_ADD;
        endcase
    end else if (cls == mips_ex_pkg::CLS_I_TYPE) begin
        case (opc)
            mips_ex_pkg::OPC_SLTI: op = mips_ex_pkg::OP_SLT;
            mips_ex_pkg::OPC_ANDI: op = mips_ex_pkg::OP_AND;
            mips_ex_pkg::OPC_ORI:  op = mips_ex_pkg::OP_OR;
            mips_ex_pkg::OPC_XORI: op = mips_ex_pkg::OP_XOR;
            mips_ex_pkg::OPC_LUI:  op = mips_ex_pkg::OP_LUI;
            default:               op = mips_ex_pkg::OP_ADD;
        endcase
    end
    return op;
endfunction

function automatic logic [31:0] ref_alu(
    input mips_ex_pkg::alu_op_e op,
    input logic [31:0]          a,
    input logic [31:0]          b,
    input logic [4:0]           sh
);
    logic [4:0]  amt;
    logic [63:0] ext;
    amt = sh;
    if (op == mips_ex_pkg::OP_SLLV || op == mips_ex_pkg::OP_SRLV ||
        op == mips_ex_pkg::OP_SRAV) begin
        amt = a[4:0];
    end
    // sign bits shifted in from the upper word
    ext = {{32{b[31]}}, b} >> amt;
    case (op)
        mips_ex_pkg::OP_ADD:  return a + b;
        mips_ex_pkg::OP_SUB:  return a - b;
        mips_ex_pkg::OP_AND:  return a & b;
        mips_ex_pkg::OP_OR:   return a | b;
        mips_ex_pkg::OP_XOR:  return a ^ b;
        mips_ex_pkg::OP_NOR:  return ~(a | b);
        mips_ex_pkg::OP_SLT:  return {31'd0, (a[31] != b[31]) ? a[31] : (a < b)};
        mips_ex_pkg::OP_SLL, mips_ex_pkg::OP_SLLV: return b << amt;
        mips_ex_pkg::OP_SRL, mips_ex_pkg::OP_SRLV: return b >> amt;
        mips_ex_pkg::OP_SRA, mips_ex_pkg::OP_SRAV: return ext[31:0];
        mips_ex_pkg::OP_LUI:  return {b[15:0], 16'h0000};
        default:              return 32'd0;
    endcase
endfunction

function automatic mips_ex_pkg::fwd_sel_e ref_fwd(
    input logic [4:0] src,
    input logic       ex_we,
    input logic [4:0] ex_reg,
    input logic       wb_we,
    input logic [4:0] wb_reg
);
    logic ex_hit;
    logic wb_hit;
    ex_hit = ex_we && (ex_reg == src) && (src != 5'd0);
    wb_hit = wb_we && (wb_reg == src) && (src != 5'd0);
    if (ex_hit) begin
        return mips_ex_pkg::FWD_EXMEM;
    end
    return wb_hit ? mips_ex_pkg::FWD_MEMWB : mips_ex_pkg::FWD_REG;
endfunction

function automatic logic [31:0] ref_operand(
    input mips_ex_pkg::fwd_sel_e sel,
    input logic [31:0]           reg_val,
    input logic [31:0]           ex_val,
    input logic [31:0]           wb_val
);
    if (sel == mips_ex_pkg::FWD_EXMEM) begin
        return ex_val;
    end else if (sel == mips_ex_pkg::FWD_MEMWB) begin
        return wb_val;
    end
    return reg_val;
endfunction

`endif

// ==== tb_execute_stage.sv ====
`timescale 1ns/1ps

module tb_execute_stage;

    `include "tb_ref_model.svh"

    localparam int N_MEM   = 20;
    localparam int N_FWD   = 80;
    localparam int N_STALL = 40;
    localparam int N_INSTR = 4 * 21 + N_MEM + N_FWD + N_STALL + 8;
    localparam logic [5:0] FN_LIST [14] = '{
        mips_ex_pkg::FN_SLL, mips_ex_pkg::FN_SRL, mips_ex_pkg::FN_SRA,
        mips_ex_pkg::FN_SLLV, mips_ex_pkg::FN_SRLV, mips_ex_pkg::FN_SRAV,
        mips_ex_pkg::FN_ADDU, mips_ex_pkg::FN_SUBU, mips_ex_pkg::FN_AND,
        mips_ex_pkg::FN_OR, mips_ex_pkg::FN_XOR, mips_ex_pkg::FN_NOR,
        mips_ex_pkg::FN_SLT, 6'b111111
    };
    localparam logic [5:0] OPC_LIST [7] = '{
        mips_ex_pkg::OPC_ADDI, mips_ex_pkg::OPC_SLTI, mips_ex_pkg::OPC_ANDI,
        mips_ex_pkg::OPC_ORI, mips_ex_pkg::OPC_XORI, mips_ex_pkg::OPC_LUI, 6'b111111
    };

    logic clk;
    logic i_rst_n, i_stall, i_halt;
    logic [mips_ex_pkg::NB_REG-1:0] i_rs, i_rt, i_rd, i_memwb_write_reg;
    logic [mips_ex_pkg::NB_DATA-1:0] i_reg_da, i_reg_db, i_immediate, i_memwb_result;
    logic [5:0] i_opcode, i_func;
    logic [4:0] i_shamt;
    logic i_jump, i_reg_dst, i_mem2reg, i_mem_read, i_mem_write, i_reg_write;
    logic i_imm_flag, i_sign_flag, i_memwb_reg_write;
    logic [1:0] i_alu_class, i_width;
    logic o_mem2reg, o_mem_read, o_mem_write, o_reg_write, o_jump, o_sign_flag;
    logic [1:0] o_width;
    logic [mips_ex_pkg::NB_REG-1:0] o_write_reg;
    logic [mips_ex_pkg::NB_DATA-1:0] o_data4mem, o_result;

    // expected ex/mem registers
    logic exp_mem2reg, exp_mem_read, exp_mem_write, exp_reg_write, exp_jump, exp_sign_flag;
    logic [1:0] exp_width;
    logic [mips_ex_pkg::NB_REG-1:0] exp_write_reg;
    logic [mips_ex_pkg::NB_DATA-1:0] exp_data4mem, exp_result;

    logic [31:0] lfsr_state;
    int          errors = 0;

    tb_clock_gen #(.PERIOD_NS(100)) clock_gen_inst (.clk(clk));

    execute_stage execute_stage_inst (.*);

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
        return val;
    endfunction

    // mostly hits older destinations or register zero
    function automatic logic [4:0] pick_reg();
        logic [1:0] k;
        k = 2'(rand_bits(2));
        if (k == 2'd0) begin
            return exp_write_reg;
        end else if (k == 2'd1) begin
            return i_memwb_write_reg;
        end else if (k == 2'd2) begin
            return 5'd0;
        end
        return 5'(rand_bits(5));
    endfunction

    task automatic check_data(input string name, input logic [mips_ex_pkg::NB_DATA-1:0] got,
                              input logic [mips_ex_pkg::NB_DATA-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t %s got=%h exp=%h", $time, name, got, exp);
            $display("TEST FAIL");
            $fatal(1, "data output mismatch");
        end
    endtask

    task automatic check_reg(input string name, input logic [mips_ex_pkg::NB_REG-1:0] got,
                             input logic [mips_ex_pkg::NB_REG-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t %s got=%0d exp=%0d", $time, name, got, exp);
            $display("TEST FAIL");
            $fatal(1, "register number mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t %s got=%b exp=%b", $time, name, got, exp);
            $display("TEST FAIL");
            $fatal(1, "control bit mismatch");
        end
    endtask

    task automatic check_width(input string name, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t %s got=%b exp=%b", $time, name, got, exp);
            $display("TEST FAIL");
            $fatal(1, "width mismatch");
        end
    endtask

    task automatic drive_random(input logic [1:0] cls, input logic [5:0] code, input logic fwd_on);
        i_alu_class       = cls;
        i_func            = code;
        i_opcode          = code;
        i_rs              = 5'(rand_bits(5));
        i_rt              = 5'(rand_bits(5));
        i_rd              = 5'(rand_bits(5));
        i_reg_da          = rand_bits(32);
        i_reg_db          = rand_bits(32);
        i_immediate       = rand_bits(32);
        i_shamt           = 5'(rand_bits(5));
        i_reg_dst         = 1'(rand_bits(1));
        i_mem2reg         = 1'(rand_bits(1));
        i_mem_read        = 1'(rand_bits(1));
        i_mem_write       = 1'(rand_bits(1));
        i_jump            = 1'(rand_bits(1));
        i_sign_flag       = 1'(rand_bits(1));
        i_imm_flag        = 1'(rand_bits(1));
        i_width           = 2'(rand_bits(2));
        i_reg_write       = fwd_on & 1'(rand_bits(1));
        i_memwb_reg_write = fwd_on & 1'(rand_bits(1));
        i_memwb_write_reg = 5'(rand_bits(5));
        i_memwb_result    = rand_bits(32);
        i_stall           = 1'b0;
        i_halt            = 1'b0;
    endtask

    task automatic drive_dependent();
        logic [1:0] cls;
        cls = 2'(rand_bits(2));
        if (cls == mips_ex_pkg::CLS_R_TYPE) begin
            drive_random(cls, FN_LIST[rand_bits(8) % 14], 1'b1);
        end else begin
            drive_random(cls, OPC_LIST[rand_bits(8) % 7], 1'b1);
        end
        // same register in both stages checks the priority
        i_memwb_write_reg = rand_bits(1) ? exp_write_reg : 5'(rand_bits(5));
        i_rs = pick_reg();
        i_rt = pick_reg();
        i_rd = 5'(rand_bits(2));
    endtask

    always @(posedge clk or negedge i_rst_n) begin : predict
        mips_ex_pkg::fwd_sel_e sel_a;
        mips_ex_pkg::fwd_sel_e sel_b;
        logic [31:0] opa;
        logic [31:0] opb;
        if (!i_rst_n) begin
            {exp_mem2reg, exp_mem_read, exp_mem_write, exp_reg_write} = 4'b0000;
            {exp_jump, exp_sign_flag} = 2'b00;
            exp_width     = 2'b11;
            exp_write_reg = '0;
            exp_data4mem  = '0;
            exp_result    = '0;
        end else if (!i_halt) begin
            sel_a = ref_fwd(i_rs, exp_reg_write, exp_write_reg, i_memwb_reg_write,
                            i_memwb_write_reg);
            sel_b = ref_fwd(i_rt, exp_reg_write, exp_write_reg, i_memwb_reg_write,
                            i_memwb_write_reg);
            opa = ref_operand(sel_a, i_reg_da, exp_result, i_memwb_result);
            opb = ref_operand(sel_b, i_reg_db, exp_result, i_memwb_result);
            exp_result    = ref_alu(ref_alu_op(i_alu_class, i_func, i_opcode), opa,
                                    i_imm_flag ? i_immediate : opb, i_shamt);
            exp_data4mem  = opb;
            exp_write_reg = i_reg_dst ? i_rt : i_rd;
            exp_mem_read  = i_mem_read & ~i_stall;
            exp_mem_write = i_mem_write & ~i_stall;
            exp_reg_write = i_reg_write & ~i_stall;
            exp_jump      = i_jump & ~i_stall;
            exp_mem2reg   = i_mem2reg;
            exp_sign_flag = i_sign_flag;
            exp_width     = i_width;
        end
    end

    // sample well after the edge
    always @(posedge clk) begin
        #25;
        check_bit("o_mem2reg", o_mem2reg, exp_mem2reg);
        check_bit("o_mem_read", o_mem_read, exp_mem_read);
        check_bit("o_mem_write", o_mem_write, exp_mem_write);
        check_bit("o_reg_write", o_reg_write, exp_reg_write);
        check_bit("o_jump", o_jump, exp_jump);
        check_bit("o_sign_flag", o_sign_flag, exp_sign_flag);
        check_width("o_width", o_width, exp_width);
        check_reg("o_write_reg", o_write_reg, exp_write_reg);
        check_data("o_data4mem", o_data4mem, exp_data4mem);
        check_data("o_result", o_result, exp_result);
    end

    initial begin
        #((N_INSTR + 20) * 100);
        $display("timeout, the instruction stream did not finish in time");
        $display("TEST FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        lfsr_state = 32'h204bb18b;
        i_rst_n = 1'b0;
        drive_random(mips_ex_pkg::CLS_LOAD_STORE, 6'd0, 1'b0);
        // first edge after reset is halted so the reset values stay visible
        i_halt = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        i_rst_n = 1'b1;
        for (int r = 0; r < 4; r++) begin
            for (int j = 0; j < 14; j++) begin
                @(negedge clk);
                drive_random(mips_ex_pkg::CLS_R_TYPE, FN_LIST[j], 1'b0);
            end
            for (int j = 0; j < 7; j++) begin
                @(negedge clk);
                drive_random(mips_ex_pkg::CLS_I_TYPE, OPC_LIST[j], 1'b0);
                i_imm_flag = 1'b1;
            end
        end
        for (int n = 0; n < N_MEM; n++) begin
            @(negedge clk);
            drive_random(n[0] ? mips_ex_pkg::CLS_BRANCH : mips_ex_pkg::CLS_LOAD_STORE,
                         6'(rand_bits(6)), 1'b0);
            i_imm_flag = ~n[0];
        end
        for (int n = 0; n < N_FWD; n++) begin
            @(negedge clk);
            drive_dependent();
        end
        for (int n = 0; n < N_STALL; n++) begin
            @(negedge clk);
            drive_dependent();
            i_stall = (rand_bits(2) == 0);
            i_halt  = (rand_bits(3) == 0);
        end
        repeat (4) begin
            @(negedge clk);
            drive_dependent();
            i_halt = 1'b1;
        end
        repeat (4) begin
            @(negedge clk);
            drive_dependent();
        end
        @(negedge clk);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
